// ==== game_link_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module game_link_top #(
    parameter int BAUD_DIV = 16
) (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       rxd,
    input  logic [7:0] sw,
    output logic       txd,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5
);

    game_pkg::key_dir_e direction;
    logic               fire;
    logic               key_valid;
    logic               key_accept;
    logic [7:0]         key_code;
    logic [7:0]         seq_cnt;
    logic               tx_start;
    logic               tx_busy;
    logic [23:0]        tx_word;
    logic [23:0]        rx_word;
    logic               rx_done;
    logic               rx_error;

    ps2_keyboard u_keyboard (
        .sys_clk   (sys_clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .direction (direction),
        .fire      (fire),
        .key_valid (key_valid)
    );

    // fire wins, arrows map in enum order from the base code
    always_comb begin
        if (fire) begin
            key_code = game_pkg::KEY_CODE_FIRE;
        end else begin
            key_code = game_pkg::KEY_CODE_BASE + {6'd0, direction};
        end
    end

    // events during a transmission are dropped
    assign key_accept = key_valid && !tx_busy && !tx_start;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            tx_start <= 1'b0;
            seq_cnt  <= '0;
        end else begin
            tx_start <= key_accept;
            if (key_accept) begin
                seq_cnt <= seq_cnt + 8'd1;
            end
        end
    end

    // sw, sequence count, event code
    always_ff @(posedge sys_clk) begin
        if (key_accept) begin
            tx_word <= {sw, seq_cnt, key_code};
        end
    end

    spart_link #(
        .BAUD_DIV (BAUD_DIV)
    ) u_link (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_word  (tx_word),
        .rxd      (rxd),
        .txd      (txd),
        .tx_busy  (tx_busy),
        .rx_word  (rx_word),
        .rx_done  (rx_done),
        .rx_error (rx_error)
    );

    hex_display u_display (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .rx_word (rx_word),
        .rx_done (rx_done),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3),
        .hex4    (hex4),
        .hex5    (hex5)
    );

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    // arrow direction, the order sets the event code offset
    typedef enum logic [1:0] {
        DIR_LEFT  = 2'd0,
        DIR_RIGHT = 2'd1,
        DIR_UP    = 2'd2,
        DIR_DOWN  = 2'd3
    } key_dir_e;

    // event codes sent in bits 7:0 of a key word
    localparam logic [7:0] KEY_CODE_BASE = 8'd102;
    localparam logic [7:0] KEY_CODE_FIRE = 8'd106;

    // active low segments, bit 6 is segment g
    localparam logic [6:0] SEG_DIGITS [16] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    // ps2 set 2 scan codes, arrows follow the E0 prefix
    localparam logic [7:0] SCAN_UP    = 8'h75;
    localparam logic [7:0] SCAN_DOWN  = 8'h72;
    localparam logic [7:0] SCAN_LEFT  = 8'h6B;
    localparam logic [7:0] SCAN_RIGHT = 8'h74;
    localparam logic [7:0] SCAN_SPACE = 8'h29;
    localparam logic [7:0] SCAN_EXT   = 8'hE0;
    localparam logic [7:0] SCAN_BREAK = 8'hF0;

    // prefix tracking in the keyboard decoder
    typedef enum logic [1:0] {
        PS2_IDLE      = 2'd0,
        PS2_EXT       = 2'd1,
        PS2_BREAK     = 2'd2,
        PS2_EXT_BREAK = 2'd3
    } ps2_state_e;

    // serial receiver phases
    typedef enum logic [1:0] {
        LINK_IDLE  = 2'd0,
        LINK_START = 2'd1,
        LINK_DATA  = 2'd2,
        LINK_STOP  = 2'd3
    } link_state_e;

endpackage

`default_nettype wire

// ==== hex_display.sv ====
`timescale 1ns/100ps
`default_nettype none

module hex_display (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic [23:0] rx_word,
    input  logic        rx_done,
    output logic [6:0]  hex0,
    output logic [6:0]  hex1,
    output logic [6:0]  hex2,
    output logic [6:0]  hex3,
    output logic [6:0]  hex4,
    output logic [6:0]  hex5
);

    logic [23:0] shown_word;

    // last good word, all zero digits after reset
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            shown_word <= '0;
        end else if (rx_done) begin
            shown_word <= rx_word;
        end
    end

    // one digit per nibble, hex0 is the lowest
    assign hex0 = game_pkg::SEG_DIGITS[shown_word[3:0]];
    assign hex1 = game_pkg::SEG_DIGITS[shown_word[7:4]];
    assign hex2 = game_pkg::SEG_DIGITS[shown_word[11:8]];
    assign hex3 = game_pkg::SEG_DIGITS[shown_word[15:12]];
    assign hex4 = game_pkg::SEG_DIGITS[shown_word[19:16]];
    assign hex5 = game_pkg::SEG_DIGITS[shown_word[23:20]];

endmodule

`default_nettype wire

// ==== ps2_keyboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard (
    input  logic               sys_clk,
    input  logic               rst_n,
    input  logic               ps2_clk,
    input  logic               ps2_data,
    output game_pkg::key_dir_e direction,
    output logic               fire,
    output logic               key_valid
);

    logic                 clk_meta;
    logic                 clk_sync;
    logic                 clk_prev;
    logic                 data_meta;
    logic                 data_sync;
    logic                 ps2_fall;
    logic [10:0]          frame;
    logic [3:0]           bit_cnt;
    logic                 frame_rdy;
    logic [7:0]           rx_byte;
    logic                 byte_ok;
    logic                 is_arrow;
    game_pkg::key_dir_e   arrow_dir;
    game_pkg::ps2_state_e state;
    logic                 hit;
    logic                 hit_fire;
    game_pkg::key_dir_e   hit_dir;

    // two stage synchronizer, lines idle high
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            clk_meta  <= 1'b1;
            clk_sync  <= 1'b1;
            clk_prev  <= 1'b1;
            data_meta <= 1'b1;
            data_sync <= 1'b1;
        end else begin
            clk_meta  <= ps2_clk;
            clk_sync  <= clk_meta;
            clk_prev  <= clk_sync;
            data_meta <= ps2_data;
            data_sync <= data_meta;
        end
    end

    assign ps2_fall = clk_prev & ~clk_sync;

    // bit count, a high start bit is not counted
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            frame_rdy <= 1'b0;
        end else begin
            frame_rdy <= 1'b0;
            if (ps2_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt   <= '0;
                    frame_rdy <= 1'b1;
                end else if (bit_cnt != 4'd0 || !data_sync) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // lsb first, so the start bit ends up in frame[0]
    always_ff @(posedge sys_clk) begin
        if (ps2_fall) begin
            frame <= {data_sync, frame[10:1]};
        end
    end

    assign rx_byte = frame[8:1];

    // start low, stop high, odd parity over data and parity bit
    assign byte_ok = frame_rdy & ~frame[0] & frame[10] & (^frame[9:1]);

    always_comb begin
        is_arrow  = 1'b1;
        arrow_dir = game_pkg::DIR_LEFT;
        case (rx_byte)
            game_pkg::SCAN_LEFT:  arrow_dir = game_pkg::DIR_LEFT;
            game_pkg::SCAN_RIGHT: arrow_dir = game_pkg::DIR_RIGHT;
            game_pkg::SCAN_UP:    arrow_dir = game_pkg::DIR_UP;
            game_pkg::SCAN_DOWN:  arrow_dir = game_pkg::DIR_DOWN;
            default:              is_arrow  = 1'b0;
        endcase
    end

    // prefix tracking, only make codes of the five keys hit
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state <= game_pkg::PS2_IDLE;
            hit   <= 1'b0;
        end else begin
            hit <= 1'b0;
            if (byte_ok) begin
                case (state)
                    game_pkg::PS2_IDLE: begin
                        if (rx_byte == game_pkg::SCAN_EXT) begin
                            state <= game_pkg::PS2_EXT;
                        end else if (rx_byte == game_pkg::SCAN_BREAK) begin
                            state <= game_pkg::PS2_BREAK;
                        end else if (rx_byte == game_pkg::SCAN_SPACE) begin
                            hit <= 1'b1;
                        end
                    end
                    game_pkg::PS2_EXT: begin
                        if (rx_byte == game_pkg::SCAN_BREAK) begin
                            state <= game_pkg::PS2_EXT_BREAK;
                        end else begin
                            state <= game_pkg::PS2_IDLE;
                            hit   <= is_arrow;
                        end
                    end
                    // released key byte is dropped
                    default: state <= game_pkg::PS2_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (byte_ok) begin
            hit_fire <= (rx_byte == game_pkg::SCAN_SPACE);
            hit_dir  <= arrow_dir;
        end
    end

    // output stage
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            key_valid <= 1'b0;
        end else begin
            key_valid <= hit;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (hit) begin
            fire      <= hit_fire;
            direction <= hit_dir;
        end
    end

    // a PS/2 frame spans many cycles, so events never merge
    a_key_valid_pulse: assert property (
        @(posedge sys_clk) disable iff (!rst_n) key_valid |=> !key_valid
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_game_link \
    -f verilog.f
./obj_dir/Vtb_game_link

// ==== spart_link.sv ====
`timescale 1ns/100ps
`default_nettype none

module spart_link #(
    parameter int BAUD_DIV = 16
) (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [23:0] tx_word,
    input  logic        rxd,
    output logic        txd,
    output logic        tx_busy,
    output logic [23:0] rx_word,
    output logic        rx_done,
    output logic        rx_error
);

    localparam int               CNT_W     = $clog2(BAUD_DIV);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BAUD_DIV - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD_DIV / 2 - 1);

    logic [CNT_W-1:0]      tx_timer;
    logic [3:0]            tx_bit;
    logic [1:0]            tx_byte;
    logic [29:0]           tx_frame;
    logic                  tx_shift;

    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  rxd_prev;
    game_pkg::link_state_e rx_state;
    logic [CNT_W-1:0]      rx_timer;
    logic [2:0]            rx_bit;
    logic [1:0]            rx_byte;
    logic [23:0]           rx_shift;

    // transmitter

    assign tx_shift = tx_busy && (tx_timer == BIT_LAST);

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            txd      <= 1'b1;
            tx_busy  <= 1'b0;
            tx_timer <= '0;
            tx_bit   <= '0;
            tx_byte  <= '0;
        end else if (!tx_busy) begin
            tx_timer <= '0;
            tx_bit   <= '0;
            tx_byte  <= '0;
            if (tx_start) begin
                // start bit of the first byte
                txd     <= 1'b0;
                tx_busy <= 1'b1;
            end
        end else if (tx_shift) begin
            tx_timer <= '0;
            if (tx_bit == 4'd9) begin
                tx_bit <= '0;
                if (tx_byte == 2'd2) begin
                    // last stop bit done
                    tx_busy <= 1'b0;
                    txd     <= 1'b1;
                end else begin
                    tx_byte <= tx_byte + 2'd1;
                    txd     <= tx_frame[1];
                end
            end else begin
                tx_bit <= tx_bit + 4'd1;
                txd    <= tx_frame[1];
            end
        end else begin
            tx_timer <= tx_timer + 1'b1;
        end
    end

    // three framed bytes back to back, low byte first
    always_ff @(posedge sys_clk) begin
        if (!tx_busy && tx_start) begin
            tx_frame <= {1'b1, tx_word[23:16], 1'b0,
                         1'b1, tx_word[15:8],  1'b0,
                         1'b1, tx_word[7:0],   1'b0};
        end else if (tx_shift) begin
            tx_frame <= {1'b1, tx_frame[29:1]};
        end
    end

    // receiver

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            rx_state <= game_pkg::LINK_IDLE;
            rx_timer <= '0;
            rx_bit   <= '0;
            rx_byte  <= '0;
            rx_done  <= 1'b0;
            rx_error <= 1'b0;
        end else begin
            rx_done  <= 1'b0;
            rx_error <= 1'b0;
            case (rx_state)
                game_pkg::LINK_IDLE: begin
                    rx_timer <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        rx_state <= game_pkg::LINK_START;
                    end
                end
                game_pkg::LINK_START: begin
                    // half a bit to reach the middle
                    if (rx_timer == HALF_LAST) begin
                        rx_timer <= '0;
                        rx_bit   <= '0;
                        if (rxd_sync) begin
                            rx_state <= game_pkg::LINK_IDLE;
                        end else begin
                            rx_state <= game_pkg::LINK_DATA;
                        end
                    end else begin
                        rx_timer <= rx_timer + 1'b1;
                    end
                end
                game_pkg::LINK_DATA: begin
                    if (rx_timer == BIT_LAST) begin
                        rx_timer <= '0;
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= game_pkg::LINK_STOP;
                        end
                    end else begin
                        rx_timer <= rx_timer + 1'b1;
                    end
                end
                game_pkg::LINK_STOP: begin
                    if (rx_timer == BIT_LAST) begin
                        rx_timer <= '0;
                        rx_state <= game_pkg::LINK_IDLE;
                        if (!rxd_sync) begin
                            // framing error drops the partial word
                            rx_error <= 1'b1;
                            rx_byte  <= '0;
                        end else if (rx_byte == 2'd2) begin
                            rx_done <= 1'b1;
                            rx_byte <= '0;
                        end else begin
                            rx_byte <= rx_byte + 2'd1;
                        end
                    end else begin
                        rx_timer <= rx_timer + 1'b1;
                    end
                end
                default: rx_state <= game_pkg::LINK_IDLE;
            endcase
        end
    end

    // 24 bits lsb first, first byte lands in 7:0
    always_ff @(posedge sys_clk) begin
        if (rx_state == game_pkg::LINK_DATA && rx_timer == BIT_LAST) begin
            rx_shift <= {rxd_sync, rx_shift[23:1]};
        end
    end

    assign rx_word = rx_shift;

    a_no_start_when_busy: assert property (
        @(posedge sys_clk) disable iff (!rst_n) !(tx_start && tx_busy)
    );

    a_done_error_excl: assert property (
        @(posedge sys_clk) disable iff (!rst_n) !(rx_done && rx_error)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic sys_clk,
    output logic rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end

    // reset released on a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_game_link.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_game_link;

    localparam int BAUD_DIV      = 16;
    localparam int PS2_HALF      = 4;
    localparam int WORD_TIMEOUT  = 4000;
    localparam int RX_TIMEOUT    = 2000;
    localparam int QUIET_CYCLES  = 800;
    localparam int RESET_TIMEOUT = 50;

    logic        sys_clk;
    logic        rst_n;
    logic        ps2_clk;
    logic        ps2_data;
    logic        rxd;
    logic        txd;
    logic        drv_rxd;
    logic        loop_sel;
    logic [7:0]  sw;
    logic [41:0] hex_all;
    logic [23:0] word_q [$];
    logic [7:0]  exp_count;
    logic [23:0] shown_word;
    integer      seed;
    int          rx_done_count;
    int          rx_error_count;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (8)
    ) u_clock (
        .sys_clk (sys_clk),
        .rst_n   (rst_n)
    );

    // loopback or driven serial frames
    assign rxd = loop_sel ? txd : drv_rxd;

    game_link_top #(
        .BAUD_DIV (BAUD_DIV)
    ) uut (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rxd      (rxd),
        .sw       (sw),
        .txd      (txd),
        .hex0     (hex_all[6:0]),
        .hex1     (hex_all[13:7]),
        .hex2     (hex_all[20:14]),
        .hex3     (hex_all[27:21]),
        .hex4     (hex_all[34:28]),
        .hex5     (hex_all[41:35])
    );

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [41:0] got,
                               input logic [41:0] expected);
        assert (got === expected) else begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, expected);
            fail_run();
        end
    endtask

    a_txd_idle_high: assert property (
        @(posedge sys_clk) disable iff (!rst_n) !uut.tx_busy |-> txd
    ) else begin
        $display("txd left the idle level while the transmitter was idle");
        fail_run();
    end

    a_start_after_key: assert property (
        @(posedge sys_clk) disable iff (!rst_n)
        (uut.key_valid && !uut.tx_busy) |=> uut.tx_start
    ) else begin
        $display("tx_start did not follow a key event on an idle link");
        fail_run();
    end

    a_error_keeps_digits: assert property (
        @(posedge sys_clk) disable iff (!rst_n) uut.rx_error |=> $stable(hex_all)
    ) else begin
        $display("digits changed after a framing error");
        fail_run();
    end

    // pulse counters for the receive side
    always @(posedge sys_clk) begin
        if (!rst_n) begin
            rx_done_count  <= 0;
            rx_error_count <= 0;
        end else begin
            if (uut.rx_done) begin
                rx_done_count <= rx_done_count + 1;
            end
            if (uut.rx_error) begin
                rx_error_count <= rx_error_count + 1;
            end
        end
    end

    // serial monitor sampling txd near each bit middle
    initial begin : serial_monitor
        logic [23:0] word;
        logic        txd_prev;
        txd_prev = 1'b1;
        forever begin
            @(negedge sys_clk);
            if (rst_n && txd_prev && !txd) begin
                repeat (BAUD_DIV / 2 - 1) @(negedge sys_clk);
                for (int b = 0; b < 3; b++) begin
                    if (b > 0) begin
                        repeat (BAUD_DIV) @(negedge sys_clk);
                    end
                    check_value("txd start bit", {41'd0, txd}, 42'd0);
                    for (int i = 0; i < 8; i++) begin
                        repeat (BAUD_DIV) @(negedge sys_clk);
                        word[b * 8 + i] = txd;
                    end
                    repeat (BAUD_DIV) @(negedge sys_clk);
                    check_value("txd stop bit", {41'd0, txd}, 42'd1);
                end
                word_q.push_back(word);
            end
            txd_prev = txd;
        end
    end

    // one PS/2 frame with data changing while the clock is high
    task automatic send_ps2_byte(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge sys_clk);
            ps2_data <= bits[i];
            repeat (PS2_HALF) @(posedge sys_clk);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge sys_clk);
            ps2_clk <= 1'b1;
        end
        @(posedge sys_clk);
        ps2_data <= 1'b1;
        repeat (20) @(posedge sys_clk);
    endtask

    task automatic send_key(input logic [7:0] scan, input logic ext);
        if (ext) begin
            send_ps2_byte(game_pkg::SCAN_EXT, 1'b0);
        end
        send_ps2_byte(scan, 1'b0);
    endtask

    task automatic send_break(input logic [7:0] scan, input logic ext);
        if (ext) begin
            send_ps2_byte(game_pkg::SCAN_EXT, 1'b0);
        end
        send_ps2_byte(game_pkg::SCAN_BREAK, 1'b0);
        send_ps2_byte(scan, 1'b0);
    endtask

    task automatic drive_serial_bit(input logic value);
        @(posedge sys_clk);
        drv_rxd <= value;
        repeat (BAUD_DIV - 1) @(posedge sys_clk);
    endtask

    // bad_stop zeroes the stop bit of the last byte
    task automatic send_serial_word(input logic [23:0] word, input logic bad_stop);
        for (int b = 0; b < 3; b++) begin
            drive_serial_bit(1'b0);
            for (int i = 0; i < 8; i++) begin
                drive_serial_bit(word[b * 8 + i]);
            end
            drive_serial_bit(!(bad_stop && b == 2));
        end
        @(posedge sys_clk);
        drv_rxd <= 1'b1;
        repeat (2 * BAUD_DIV) @(posedge sys_clk);
    endtask

    task automatic wait_word(output logic [23:0] word);
        int n;
        n = 0;
        while (word_q.size() == 0 && n < WORD_TIMEOUT) begin
            @(posedge sys_clk);
            n++;
        end
        assert (word_q.size() != 0) else begin
            $display("timeout waiting for a serial word on txd");
            fail_run();
        end
        word = word_q.pop_front();
    endtask

    task automatic expect_no_word();
        repeat (QUIET_CYCLES) @(posedge sys_clk);
        assert (word_q.size() == 0) else begin
            $display("a serial word was sent for an event that should be dropped");
            fail_run();
        end
    endtask

    task automatic wait_rx_event(input logic want_error, input int start_count);
        int n;
        int cnt;
        n = 0;
        cnt = want_error ? rx_error_count : rx_done_count;
        while (cnt == start_count && n < RX_TIMEOUT) begin
            @(posedge sys_clk);
            n++;
            cnt = want_error ? rx_error_count : rx_done_count;
        end
        assert (cnt != start_count) else begin
            $display("timeout waiting for %s", want_error ? "rx_error" : "rx_done");
            fail_run();
        end
    endtask

    task automatic check_digits(input logic [23:0] word);
        for (int i = 0; i < 6; i++) begin
            check_value($sformatf("hex%0d", i), {35'd0, hex_all[i * 7 +: 7]},
                        {35'd0, game_pkg::SEG_DIGITS[word[i * 4 +: 4]]});
        end
    endtask

    task automatic set_random_sw(output logic [7:0] value);
        int rnd;
        rnd = $random(seed);
        value = rnd[7:0];
        @(posedge sys_clk);
        sw <= value;
    endtask

    // key press with loopback word and digit check
    task automatic press_and_check(input logic [7:0] scan, input logic ext,
                                   input logic [7:0] code);
        logic [7:0]  sw_val;
        logic [23:0] got;
        logic [23:0] exp_word;
        int          done_start;
        set_random_sw(sw_val);
        exp_word = {sw_val, exp_count, code};
        done_start = rx_done_count;
        send_key(scan, ext);
        wait_word(got);
        check_value("serial word", {18'd0, got}, {18'd0, exp_word});
        exp_count = exp_count + 8'd1;
        wait_rx_event(1'b0, done_start);
        @(negedge sys_clk);
        check_digits(exp_word);
        shown_word = exp_word;
    endtask

    initial begin : main
        logic [7:0]  sw_val;
        logic [23:0] got;
        logic [23:0] exp_word;
        int          done_start;
        int          err_start;
        int          rnd;
        int          n;
        seed = 39898;
        exp_count = 8'd0;
        shown_word = 24'd0;
        ps2_clk <= 1'b1;
        ps2_data <= 1'b1;
        drv_rxd <= 1'b1;
        loop_sel <= 1'b1;
        sw <= 8'd0;

        n = 0;
        while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
            @(posedge sys_clk);
            n++;
        end
        assert (rst_n === 1'b1) else begin
            $display("reset was never released");
            fail_run();
        end
        repeat (4) @(negedge sys_clk);

        // idle state after reset
        check_value("txd", {41'd0, txd}, 42'd1);
        check_digits(24'd0);

        // codes 102 to 105 in direction order and 106 for fire
        press_and_check(game_pkg::SCAN_UP, 1'b1, 8'd104);
        press_and_check(game_pkg::SCAN_DOWN, 1'b1, 8'd105);
        press_and_check(game_pkg::SCAN_LEFT, 1'b1, 8'd102);
        press_and_check(game_pkg::SCAN_RIGHT, 1'b1, 8'd103);
        press_and_check(game_pkg::SCAN_SPACE, 1'b0, 8'd106);

        // releases and parity errors
        send_break(game_pkg::SCAN_SPACE, 1'b0);
        send_break(game_pkg::SCAN_LEFT, 1'b1);
        send_ps2_byte(game_pkg::SCAN_SPACE, 1'b1);
        expect_no_word();
        press_and_check(game_pkg::SCAN_LEFT, 1'b1, 8'd102);

        // second event lands while the first word is on the line
        set_random_sw(sw_val);
        exp_word = {sw_val, exp_count, 8'd106};
        done_start = rx_done_count;
        send_key(game_pkg::SCAN_SPACE, 1'b0);
        send_key(game_pkg::SCAN_DOWN, 1'b1);
        wait_word(got);
        check_value("serial word", {18'd0, got}, {18'd0, exp_word});
        exp_count = exp_count + 8'd1;
        expect_no_word();
        wait_rx_event(1'b0, done_start);
        @(negedge sys_clk);
        check_digits(exp_word);
        shown_word = exp_word;
        press_and_check(game_pkg::SCAN_RIGHT, 1'b1, 8'd103);

        // driven frames starting with a zero stop bit
        @(posedge sys_clk);
        loop_sel <= 1'b0;
        rnd = $random(seed);
        err_start = rx_error_count;
        done_start = rx_done_count;
        send_serial_word(rnd[23:0], 1'b1);
        wait_rx_event(1'b1, err_start);
        repeat (4) @(negedge sys_clk);
        check_digits(shown_word);
        check_value("rx_done count", 42'(rx_done_count), 42'(done_start));
        rnd = $random(seed);
        send_serial_word(rnd[23:0], 1'b0);
        wait_rx_event(1'b0, done_start);
        @(negedge sys_clk);
        check_digits(rnd[23:0]);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
game_pkg.sv
ps2_keyboard.sv
spart_link.sv
hex_display.sv
game_link_top.sv
tb_clock.sv
tb_game_link.sv
